/* verilog.f */
+incdir+hw
hw/mam_pkg.sv
hw/mam_wb_master.sv
hw/mam_wb_decode.sv
hw/mam_wb_ram.sv
hw/mam_wb_regs.sv
hw/mam_wb_sys.sv
dv/mam_wb_sys_chk.sv
dv/mam_wb_sys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the mam_wb_sys testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module mam_wb_sys_tb \
   -f verilog.f \
   -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Regression failed" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi
echo "Simulation finished without failure"

/* dv/mam_wb_sys_tb.sv */
`include "mam_consts.svh"

module mam_wb_sys_tb import mam_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD      = 20;
   localparam int RESET_CYCLES    = 16;
   localparam int SINGLE_N        = 8;
   localparam int CYCLES_PER_BEAT = 8;
   // Singles, burst pair with its single reads, register, unmapped and alias beats
   localparam int TOTAL_BEATS     = 2 * SINGLE_N + 16 + 8 + 9 + 8 + 4;
   localparam int WATCHDOG_CYCLES = CYCLES_PER_BEAT * TOTAL_BEATS * 2 + RESET_CYCLES;

   logic       clk_i;
   logic       rst_i;
   logic       req_valid_i, req_ready_o, req_rw_i, req_burst_i;
   mam_addr_t  req_addr_i;
   mam_beats_t req_beats_i;
   logic       write_valid_i, write_ready_o;
   mam_data_t  write_data_i;
   logic       read_valid_o, read_ready_i;
   mam_data_t  read_data_o;

   mam_data_t   ref_mem [256];     // Mirror of the RAM
   mam_data_t   scratch [2];
   int          reg_writes;        // Writes sent to the register region
   mam_data_t   wr_words[$];
   mam_data_t   rd_words[$];
   mam_data_t   exp_words[$];
   int          pass_cnt;
   int          fail_cnt;

   mam_wb_sys dut0 (.*);

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

   task automatic step();
      @(posedge clk_i);
      #2;
   endtask

   function automatic mam_data_t rand_word();
      return mam_data_t'($urandom);
   endfunction

   function automatic mam_addr_t rand_ram_addr();
      return mam_addr_t'($urandom) & 32'h0000_01FE; // Word aligned, below 512
   endfunction

   function automatic logic pick_valid(input logic gaps);
      return gaps ? ($urandom % 3 != 0) : 1'b1;
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) pass_cnt++;
      else begin
         $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, got);
         fail_cnt++;
      end
   endtask

   task automatic check_word(input string name, input mam_data_t got, input mam_data_t exp);
      assert (got === exp) pass_cnt++;
      else begin
         $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
         fail_cnt++;
      end
   endtask

   task automatic check_int(input string name, input int got, input int exp);
      assert (got == exp) pass_cnt++;
      else begin
         $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, got);
         fail_cnt++;
      end
   endtask

   task automatic report_test(input string name, input int fails_before);
      $display("Test %s finished with %0d errors", name, fail_cnt - fails_before);
   endtask

   // Called at a drive point, returns at a drive point with the master idle
   task automatic do_write(input mam_addr_t addr, input logic burst, input int beats,
                           input logic gaps);
      logic taken;
      int   sent;
      taken = 1'b0;
      sent  = 0;
      req_valid_i   = 1'b1;
      req_rw_i      = 1'b1;
      req_addr_i    = addr;
      req_burst_i   = burst;
      req_beats_i   = mam_beats_t'(beats);
      write_valid_i = pick_valid(gaps);
      write_data_i  = wr_words[0];
      while (!taken || sent < beats) begin
         @(negedge clk_i);
         if (req_valid_i && req_ready_o) taken = 1'b1;
         if (write_valid_i && write_ready_o) sent++;
         step();
         if (taken) req_valid_i = 1'b0;
         write_valid_i = (sent < beats) ? pick_valid(gaps) : 1'b0;
         if (sent < beats) write_data_i = wr_words[sent];
      end
      @(negedge clk_i);
      while (!req_ready_o) @(negedge clk_i); // Burst end is the return to idle
      step();
   endtask

   task automatic do_read(input mam_addr_t addr, input logic burst, input int beats,
                          input logic gaps);
      logic taken;
      logic early;
      taken = 1'b0;
      early = 1'b0;
      rd_words.delete();
      req_valid_i  = 1'b1;
      req_rw_i     = 1'b0;
      req_addr_i   = addr;
      req_burst_i  = burst;
      req_beats_i  = mam_beats_t'(beats);
      read_ready_i = pick_valid(gaps);
      while (!taken) begin
         @(negedge clk_i);
         taken = req_ready_o;
         step();
         read_ready_i = pick_valid(gaps);
      end
      req_valid_i = 1'b0;
      while (rd_words.size() < beats && !early) begin
         @(negedge clk_i);
         if (read_valid_o && read_ready_i) rd_words.push_back(read_data_o);
         else if (req_ready_o) early = 1'b1; // Idle before all words came back
         step();
         read_ready_i = pick_valid(gaps);
      end
      read_ready_i = 1'b0;
      @(negedge clk_i);
      check_int("read handshakes", rd_words.size(), beats);
      check_bit("req_ready_o", req_ready_o, 1'b1);
      check_bit("read_valid_o", read_valid_o, 1'b0);
      step();
   endtask

   task automatic read_expect(input mam_addr_t addr, input logic burst, input int beats,
                              input logic gaps);
      do_read(addr, burst, beats, gaps);
      for (int i = 0; i < rd_words.size() && i < exp_words.size(); i++) begin
         check_word($sformatf("read_data_o beat %0d", i), rd_words[i], exp_words[i]);
      end
   endtask

   task automatic write_ram(input mam_addr_t addr, input mam_data_t d);
      wr_words.delete();
      wr_words.push_back(d);
      do_write(addr, 1'b0, 1, 1'b1);
      ref_mem[addr[8:1]] = d;
   endtask

   task automatic read_one(input mam_addr_t addr, input mam_data_t exp);
      exp_words.delete();
      exp_words.push_back(exp);
      read_expect(addr, 1'b0, 1, 1'b1);
   endtask

   task automatic test_reset();
      int fails_before;
      fails_before = fail_cnt;
      @(negedge clk_i);
      check_bit("req_ready_o", req_ready_o, 1'b1);
      check_bit("read_valid_o", read_valid_o, 1'b0);
      check_bit("write_ready_o", write_ready_o, 1'b0);
      step();
      report_test("reset", fails_before);
   endtask

   task automatic test_single();
      mam_addr_t addrs [SINGLE_N];
      int        fails_before;
      fails_before = fail_cnt;
      for (int i = 0; i < SINGLE_N; i++) begin
         addrs[i] = rand_ram_addr();
         write_ram(addrs[i], rand_word());
      end
      for (int i = 0; i < SINGLE_N; i++) begin
         read_one(addrs[i], ref_mem[addrs[i][8:1]]);
      end
      report_test("single", fails_before);
   endtask

   task automatic test_burst();
      mam_addr_t base;
      mam_addr_t a;
      int        beats;
      int        fails_before;
      fails_before = fail_cnt;
      base  = rand_ram_addr();
      beats = 2 + int'($urandom % 7);
      wr_words.delete();
      exp_words.delete();
      for (int i = 0; i < beats; i++) begin
         wr_words.push_back(rand_word());
      end
      do_write(base, 1'b1, beats, 1'b1);
      for (int i = 0; i < beats; i++) begin
         a = base + mam_addr_t'(2 * i); // Consecutive words
         ref_mem[a[8:1]] = wr_words[i];
         exp_words.push_back(wr_words[i]);
      end
      read_expect(base, 1'b1, beats, 1'b1);
      // Each beat landed at its own word address
      for (int i = 0; i < beats; i++) begin
         a = base + mam_addr_t'(2 * i);
         read_one(a, ref_mem[a[8:1]]);
      end
      report_test("burst", fails_before);
   endtask

   task automatic test_regs();
      int fails_before;
      fails_before = fail_cnt;
      scratch[0] = rand_word();
      scratch[1] = rand_word();
      wr_words.delete();
      wr_words.push_back(scratch[0]);
      wr_words.push_back(scratch[1]);
      do_write(32'h0000_4000, 1'b1, 2, 1'b1);
      reg_writes += 2;
      scratch[1] = rand_word();
      wr_words.delete();
      wr_words.push_back(scratch[1]);
      do_write(32'h0000_4002, 1'b0, 1, 1'b0);
      reg_writes++;
      wr_words[0] = rand_word();
      do_write(32'h0000_4004, 1'b0, 1, 1'b0); // Identity is read only
      reg_writes++;
      wr_words[0] = rand_word();
      do_write(32'h0000_4006, 1'b0, 1, 1'b0); // So is the count
      reg_writes++;
      exp_words.delete();
      exp_words.push_back(scratch[0]);
      exp_words.push_back(scratch[1]);
      exp_words.push_back(`MAM_REGS_ID);
      exp_words.push_back(mam_data_t'(reg_writes));
      read_expect(32'h0000_4000, 1'b1, 4, 1'b1);
      report_test("regs", fails_before);
   endtask

   task automatic test_unmapped();
      mam_addr_t a;
      int        fails_before;
      fails_before = fail_cnt;
      a = rand_ram_addr();
      write_ram(a, rand_word());
      wr_words[0] = rand_word();
      do_write(a | 32'h0000_8000, 1'b0, 1, 1'b0);
      wr_words[0] = rand_word();
      do_write(a | 32'h0000_C000, 1'b0, 1, 1'b0);
      read_one(a | 32'h0000_8000, `MAM_UNMAPPED_DATA);
      read_one(a | 32'h0000_C000, `MAM_UNMAPPED_DATA);
      exp_words.push_back(`MAM_UNMAPPED_DATA);
      read_expect(32'h0000_C010, 1'b1, 2, 1'b1);
      read_one(a, ref_mem[a[8:1]]); // RAM word survives
      report_test("unmapped", fails_before);
   endtask

   task automatic test_alias();
      mam_addr_t a;
      mam_addr_t hi;
      int        fails_before;
      fails_before = fail_cnt;
      a  = rand_ram_addr();
      hi = mam_addr_t'(1 + $urandom % 31) << 9; // Bits 13 to 9, region 0
      write_ram(a, rand_word());
      read_one(a | hi, ref_mem[a[8:1]]);
      a = rand_ram_addr();
      write_ram(a | hi, rand_word());
      read_one(a, ref_mem[a[8:1]]);
      report_test("alias", fails_before);
   endtask

   initial begin
      void'($urandom(32'hb6de667d));
      rst_i         = 1'b1;
      req_valid_i   = 1'b0;
      req_rw_i      = 1'b0;
      req_addr_i    = '0;
      req_burst_i   = 1'b0;
      req_beats_i   = '0;
      write_valid_i = 1'b0;
      write_data_i  = '0;
      read_ready_i  = 1'b0;
      reg_writes    = 0;
      pass_cnt      = 0;
      fail_cnt      = 0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      #2;
      rst_i = 1'b0;

      test_reset();
      test_single();
      test_burst();
      test_regs();
      test_unmapped();
      test_alias();

      $display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* dv/mam_wb_sys_chk.sv */
`include "mam_consts.svh"

module mam_wb_sys_chk import mam_pkg::*; (
   input logic      clk_i,
   input logic      rst_i,
   input logic      cyc_i,
   input logic      stb_i,
   input logic      we_i,
   input mam_addr_t adr_i,
   input mam_data_t dat_i,
   input wb_cti_t   cti_i,
   input logic      ack_i
);

   timeunit 1ns;
   timeprecision 1ps;

   cyc_is_stb: assert property (@(posedge clk_i) disable iff (rst_i) cyc_i == stb_i)
      else $error("cyc and stb differ");

   // A strobe is held until the slave answers
   stb_held: assert property (@(posedge clk_i) disable iff (rst_i) stb_i && !ack_i |=> stb_i)
      else $error("stb dropped before ack");

   req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_i && !ack_i |=> $stable(adr_i) && $stable(we_i) && $stable(dat_i) && $stable(cti_i))
      else $error("adr, we, dat or cti changed while waiting for ack");

   // A beat not tagged incremental closes the cycle
   last_beat_ends: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_i && ack_i && cti_i != `MAM_CTI_INCR |=> !stb_i)
      else $error("stb continued after the final beat");

   ack_needs_stb: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |-> stb_i)
      else $error("ack without stb");

endmodule

bind mam_wb_master mam_wb_sys_chk u_chk (
   .clk_i (clk_i),
   .rst_i (rst_i),
   .cyc_i (cyc_o),
   .stb_i (stb_o),
   .we_i  (we_o),
   .adr_i (adr_o),
   .dat_i (dat_o),
   .cti_i (cti_o),
   .ack_i (ack_i)
);

/* hw/mam_wb_sys.sv */
module mam_wb_sys import mam_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,

   input  logic       req_valid_i,
   output logic       req_ready_o,
   input  logic       req_rw_i,
   input  mam_addr_t  req_addr_i,
   input  logic       req_burst_i,
   input  mam_beats_t req_beats_i,

   input  logic       write_valid_i,
   input  mam_data_t  write_data_i,
   output logic       write_ready_o,

   output logic       read_valid_o,
   output mam_data_t  read_data_o,
   input  logic       read_ready_i
);

   // Shared bus from the master
   logic      cyc, stb, we, ack;
   mam_addr_t adr;
   mam_data_t dat_w, dat_r;
   mam_sel_t  sel;
   wb_cti_t   cti;
   wb_bte_t   bte;

   // Per-slave return paths
   logic      ram_stb, ram_ack, regs_stb, regs_ack;
   mam_data_t ram_dat, regs_dat;

   mam_wb_master u_master (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .req_valid_i   (req_valid_i),
      .req_ready_o   (req_ready_o),
      .req_rw_i      (req_rw_i),
      .req_addr_i    (req_addr_i),
      .req_burst_i   (req_burst_i),
      .req_beats_i   (req_beats_i),
      .write_valid_i (write_valid_i),
      .write_data_i  (write_data_i),
      .write_ready_o (write_ready_o),
      .read_valid_o  (read_valid_o),
      .read_data_o   (read_data_o),
      .read_ready_i  (read_ready_i),
      .cyc_o         (cyc),
      .stb_o         (stb),
      .we_o          (we),
      .adr_o         (adr),
      .dat_o         (dat_w),
      .sel_o         (sel),
      .cti_o         (cti),
      .bte_o         (bte),
      .ack_i         (ack),
      .dat_i         (dat_r)
   );

   mam_wb_decode u_decode (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .stb_i      (stb & cyc),
      .adr_i      (adr),
      .ack_o      (ack),
      .dat_o      (dat_r),
      .ram_stb_o  (ram_stb),
      .ram_ack_i  (ram_ack),
      .ram_dat_i  (ram_dat),
      .regs_stb_o (regs_stb),
      .regs_ack_i (regs_ack),
      .regs_dat_i (regs_dat)
   );

   mam_wb_ram u_ram (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .stb_i (ram_stb),
      .we_i  (we),
      .adr_i (adr),
      .dat_i (dat_w),
      .sel_i (sel),
      .ack_o (ram_ack),
      .dat_o (ram_dat)
   );

   mam_wb_regs u_regs (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .stb_i (regs_stb),
      .we_i  (we),
      .adr_i (adr),
      .dat_i (dat_w),
      .sel_i (sel),
      .ack_o (regs_ack),
      .dat_o (regs_dat)
   );

endmodule

/* hw/mam_wb_regs.sv */
`include "mam_consts.svh"

module mam_wb_regs import mam_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      stb_i,
   input  logic      we_i,
   input  mam_addr_t adr_i,
   input  mam_data_t dat_i,
   input  mam_sel_t  sel_i,
   output logic      ack_o,
   output mam_data_t dat_o
);

   mam_data_t  scratch0_q;
   mam_data_t  scratch1_q;
   mam_data_t  wcnt_q;     // Writes received, wraps
   logic [1:0] idx;
   logic       access;

   assign idx    = adr_i[2:1];
   assign access = stb_i & ~ack_o;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o  <= 1'b0;
         wcnt_q <= '0;
      end else begin
         ack_o <= access;
         if (access & we_i) begin
            wcnt_q <= wcnt_q + mam_data_t'(1); // Counts read-only targets too
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (access & we_i) begin
         for (int b = 0; b < `MAM_SEL_WIDTH; b++) begin
            if (sel_i[b] && idx == 2'd0) begin
               scratch0_q[8*b +: 8] <= dat_i[8*b +: 8];
            end
            if (sel_i[b] && idx == 2'd1) begin
               scratch1_q[8*b +: 8] <= dat_i[8*b +: 8];
            end
         end
      end
      if (access) begin
         case (idx)
            2'd0:    dat_o <= scratch0_q;
            2'd1:    dat_o <= scratch1_q;
            2'd2:    dat_o <= `MAM_REGS_ID;
            default: dat_o <= wcnt_q;
         endcase
      end
   end

endmodule

/* hw/mam_wb_ram.sv */
`include "mam_consts.svh"

module mam_wb_ram import mam_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      stb_i,
   input  logic      we_i,
   input  mam_addr_t adr_i,
   input  mam_data_t dat_i,
   input  mam_sel_t  sel_i,
   output logic      ack_o,
   output mam_data_t dat_o
);

   mam_data_t mem [2**`MAM_RAM_AW];

   logic [`MAM_RAM_AW-1:0] idx;
   logic                   access;  // First strobe cycle of a beat

   assign idx    = adr_i[`MAM_RAM_AW:1]; // Upper bits alias
   assign access = stb_i & ~ack_o;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= access;
      end
   end

   always_ff @(posedge clk_i) begin
      if (access & we_i) begin
         for (int b = 0; b < `MAM_SEL_WIDTH; b++) begin
            if (sel_i[b]) begin
               mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
            end
         end
      end
      if (access) begin
         dat_o <= mem[idx]; // Presented together with ack
      end
   end

endmodule

/* hw/mam_wb_decode.sv */
`include "mam_consts.svh"

module mam_wb_decode import mam_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      stb_i,
   input  mam_addr_t adr_i,
   output logic      ack_o,
   output mam_data_t dat_o,
   output logic      ram_stb_o,
   input  logic      ram_ack_i,
   input  mam_data_t ram_dat_i,
   output logic      regs_stb_o,
   input  logic      regs_ack_i,
   input  mam_data_t regs_dat_i
);

   logic [1:0] region;
   logic       unm_stb;
   logic       unm_ack_q;  // Local answer for regions 2 and 3

   assign region     = adr_i[`MAM_REGION_HI:`MAM_REGION_LO];
   assign ram_stb_o  = stb_i & (region == 2'd0);
   assign regs_stb_o = stb_i & (region == 2'd1);
   assign unm_stb    = stb_i & region[1];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         unm_ack_q <= 1'b0;
      end else begin
         unm_ack_q <= unm_stb & ~unm_ack_q;
      end
   end

   assign ack_o = ram_ack_i | regs_ack_i | unm_ack_q;

   always_comb begin
      case (region)
         2'd0:    dat_o = ram_dat_i;
         2'd1:    dat_o = regs_dat_i;
         default: dat_o = `MAM_UNMAPPED_DATA;
      endcase
   end

endmodule

/* hw/mam_wb_master.sv */
`include "mam_consts.svh"

module mam_wb_master import mam_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,

   input  logic       req_valid_i,
   output logic       req_ready_o,
   input  logic       req_rw_i,        // 1 for write
   input  mam_addr_t  req_addr_i,
   input  logic       req_burst_i,     // Incremental burst
   input  mam_beats_t req_beats_i,

   input  logic       write_valid_i,
   input  mam_data_t  write_data_i,
   output logic       write_ready_o,

   output logic       read_valid_o,
   output mam_data_t  read_data_o,
   input  logic       read_ready_i,

   output logic       cyc_o,
   output logic       stb_o,
   output logic       we_o,
   output mam_addr_t  adr_o,
   output mam_data_t  dat_o,
   output mam_sel_t   sel_o,
   output wb_cti_t    cti_o,
   output wb_bte_t    bte_o,
   input  logic       ack_i,
   input  mam_data_t  dat_i
);

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_WRITE_WAIT,
      ST_WRITE,
      ST_WRITE_LAST,
      ST_READ_START,
      ST_READ,
      ST_READ_WAIT,
      ST_READ_LAST,
      ST_READ_LAST_WAIT
   } state_t;

   state_t     state_q, state_d;
   mam_addr_t  addr_q, addr_d;
   mam_beats_t beats_q, beats_d;
   mam_data_t  wdat_q, wdat_d;
   mam_data_t  rdat_q, rdat_d;
   wb_cti_t    cti_q, cti_d;
   logic       we_q, we_d;

   mam_beats_t req_beats;  // Beat count of the incoming request
   mam_beats_t beats_dec;
   mam_addr_t  addr_next;

   assign req_beats = req_burst_i ? req_beats_i : mam_beats_t'(1);
   assign beats_dec = beats_q - mam_beats_t'(1);
   assign addr_next = addr_q + mam_addr_t'(`MAM_SEL_WIDTH); // One word further

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
         cti_q   <= `MAM_CTI_CLASSIC;
         we_q    <= 1'b0;
      end else begin
         state_q <= state_d;
         cti_q   <= cti_d;
         we_q    <= we_d;
      end
      addr_q  <= addr_d;
      beats_q <= beats_d;
      wdat_q  <= wdat_d;
      rdat_q  <= rdat_d;
   end

   always_comb begin
      state_d = state_q;
      addr_d  = addr_q;
      beats_d = beats_q;
      wdat_d  = wdat_q;
      rdat_d  = rdat_q;
      cti_d   = cti_q;
      we_d    = we_q;

      req_ready_o   = 1'b0;
      write_ready_o = 1'b0;
      read_valid_o  = 1'b0;
      stb_o         = 1'b0;

      case (state_q)
         ST_IDLE: begin
            req_ready_o   = 1'b1;
            write_ready_o = req_valid_i & req_rw_i; // First word rides with the request
            if (req_valid_i) begin
               addr_d  = req_addr_i;
               beats_d = req_beats;
               we_d    = req_rw_i;
               if (req_beats != mam_beats_t'(1)) begin
                  cti_d = `MAM_CTI_INCR;
               end else if (req_burst_i) begin
                  cti_d = `MAM_CTI_END;
               end else begin
                  cti_d = `MAM_CTI_CLASSIC;
               end
               if (req_rw_i) begin
                  if (write_valid_i) begin
                     wdat_d  = write_data_i;
                     state_d = (req_beats == mam_beats_t'(1)) ? ST_WRITE_LAST : ST_WRITE;
                  end else begin
                     state_d = ST_WRITE_WAIT;
                  end
               end else begin
                  state_d = (req_beats == mam_beats_t'(1)) ? ST_READ_LAST : ST_READ_START;
               end
            end
         end
         ST_WRITE_WAIT: begin
            write_ready_o = 1'b1;
            if (write_valid_i) begin
               wdat_d  = write_data_i;
               state_d = (beats_q == mam_beats_t'(1)) ? ST_WRITE_LAST : ST_WRITE;
            end
         end
         ST_WRITE: begin
            stb_o = 1'b1;
            if (ack_i) begin
               write_ready_o = 1'b1; // Next word may replace the acked one
               addr_d  = addr_next;
               beats_d = beats_dec;
               if (beats_dec == mam_beats_t'(1)) begin
                  cti_d = `MAM_CTI_END;
               end
               if (write_valid_i) begin
                  wdat_d  = write_data_i;
                  state_d = (beats_dec == mam_beats_t'(1)) ? ST_WRITE_LAST : ST_WRITE;
               end else begin
                  state_d = ST_WRITE_WAIT;
               end
            end
         end
         ST_WRITE_LAST: begin
            stb_o = 1'b1;
            if (ack_i) begin
               addr_d  = addr_next;
               cti_d   = `MAM_CTI_CLASSIC;
               we_d    = 1'b0;
               state_d = ST_IDLE;
            end
         end
         // First and middle read beats share the bus phase
         ST_READ_START, ST_READ: begin
            stb_o = 1'b1;
            if (ack_i) begin
               rdat_d  = dat_i;
               addr_d  = addr_next;
               beats_d = beats_dec;
               state_d = ST_READ_WAIT;
            end
         end
         ST_READ_WAIT: begin
            read_valid_o = 1'b1; // Bus idles until the word is taken
            if (read_ready_i) begin
               if (beats_q == mam_beats_t'(1)) begin
                  cti_d   = `MAM_CTI_END;
                  state_d = ST_READ_LAST;
               end else begin
                  state_d = ST_READ;
               end
            end
         end
         ST_READ_LAST: begin
            stb_o = 1'b1;
            if (ack_i) begin
               rdat_d  = dat_i;
               addr_d  = addr_next;
               state_d = ST_READ_LAST_WAIT;
            end
         end
         ST_READ_LAST_WAIT: begin
            read_valid_o = 1'b1;
            if (read_ready_i) begin
               cti_d   = `MAM_CTI_CLASSIC;
               state_d = ST_IDLE;
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   assign cyc_o       = stb_o;
   assign we_o        = we_q;
   assign adr_o       = addr_q;
   assign dat_o       = wdat_q;
   assign sel_o       = '1;       // Full words only
   assign cti_o       = cti_q;
   assign bte_o       = 2'b00;    // Linear bursts
   assign read_data_o = rdat_q;

endmodule

/* hw/mam_pkg.sv */
`include "mam_consts.svh"

package mam_pkg;

   typedef logic [`MAM_ADDR_WIDTH-1:0] mam_addr_t; // Byte address
   typedef logic [`MAM_DATA_WIDTH-1:0] mam_data_t; // One bus word
   typedef logic [13:0] mam_beats_t;               // Burst length in words
   typedef logic [`MAM_SEL_WIDTH-1:0] mam_sel_t;   // Byte selects

   // Wishbone registered feedback tags
   typedef logic [2:0] wb_cti_t;
   typedef logic [1:0] wb_bte_t;

endpackage

/* hw/mam_consts.svh */
`ifndef MAM_CONSTS_SVH
`define MAM_CONSTS_SVH

// Bus widths
`define MAM_DATA_WIDTH 16
`define MAM_ADDR_WIDTH 32
`define MAM_SEL_WIDTH 2

// RAM word address width, 256 words
`define MAM_RAM_AW 8

// Region select bits of the byte address
`define MAM_REGION_HI 15
`define MAM_REGION_LO 14

// Fixed read values
`define MAM_UNMAPPED_DATA 16'hBAD0
`define MAM_REGS_ID 16'h4D41

// Wishbone cycle type identifiers
`define MAM_CTI_CLASSIC 3'b000
`define MAM_CTI_INCR 3'b010
`define MAM_CTI_END 3'b111

`endif
